//--- vlane_pkg.sv
package vlane_pkg;

   //////////////////////////////////////////////////////////////////////
   // Sizes and pipeline depths
   //////////////////////////////////////////////////////////////////////

   localparam int VRF_DEPTH  = 64;
   localparam int MASK_DEPTH = 32;

   // Read request to operands at the ALU
   localparam int VRF_DELAY  = 3;
   // Write command to memory write
   localparam int WB_DELAY   = 2;

   //////////////////////////////////////////////////////////////////////
   // Scalar types
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0]                     word_t;
   typedef logic [$clog2(VRF_DEPTH)-1:0]    vrf_addr_t;
   typedef logic [$clog2(MASK_DEPTH)-1:0]   mask_addr_t;
   typedef logic [3:0]                      byte_en_t;
   typedef logic [2:0]                      rport_sel_t;
   typedef logic [5:0]                      alu_ctrl_t;

   // Element width, encoding follows vsew
   typedef enum logic [1:0] {
      SEW8     = 2'd0,
      SEW16    = 2'd1,
      SEW32    = 2'd2,
      SEW_NONE = 2'd3
   } sew_e;

   typedef enum logic [1:0] {
      OP2_VS2  = 2'd0,
      OP2_XREG = 2'd1,
      OP2_IMM  = 2'd2
   } op2_sel_e;

   typedef enum logic [1:0] {
      WD_ALU  = 2'd0,
      WD_LOAD = 2'd1,
      WD_ZERO = 2'd2
   } wdata_sel_e;

   //////////////////////////////////////////////////////////////////////
   // Lane structs
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        ren;
      vrf_addr_t   addr;
      logic [1:0]  el_idx;
   } vrf_rd_req_t;

   typedef struct packed {
      op2_sel_e    op2_sel;
      rport_sel_t  op3_sel;
      word_t       x_data;
      logic [4:0]  imm;
      alu_ctrl_t   alu_ctrl;
      rport_sel_t  store_sel;
      logic        store_valid;
      logic        read_valid;
   } issue_t;

   typedef struct packed {
      vrf_addr_t   waddr;
      byte_en_t    bwen;
      wdata_sel_e  data_sel;
      logic        vm;
      mask_addr_t  mask_addr;
      logic        mask_wen;
      logic        force_wen;
   } wb_cmd_t;

   typedef struct packed {
      logic        vld;
      alu_ctrl_t   opmode;
      sew_e        sew;
      word_t       vs1;
      word_t       vs2;
      word_t       vs3;
   } alu_req_t;

endpackage

//--- vlane_regfile.sv
`timescale 1ns/1ps

module vlane_regfile #(
   parameter int NUM_RPORTS = 4,
   parameter int NUM_WPORTS = 2,
   parameter int DEPTH      = 64,
   parameter int WIDTH      = 32,
   parameter int LANES      = 4
) (
   input  logic                                            clk_i,
   input  logic                                            rst_i,

   input  logic [NUM_RPORTS-1:0]                           rd_en_i,
   input  logic [NUM_RPORTS-1:0][$clog2(DEPTH)-1:0]        rd_addr_i,
   output logic [NUM_RPORTS-1:0][WIDTH-1:0]                rd_data_o,

   input  logic [NUM_WPORTS-1:0][$clog2(DEPTH)-1:0]        wr_addr_i,
   input  logic [NUM_WPORTS-1:0][LANES-1:0]                wr_lane_en_i,
   input  logic [NUM_WPORTS-1:0][WIDTH-1:0]                wr_data_i
);

   localparam int LANE_W = WIDTH / LANES;
   localparam int AW     = $clog2(DEPTH);

   logic [DEPTH-1:0][WIDTH-1:0]         mem;
   logic [NUM_RPORTS-1:0]               rd_en_q;
   logic [NUM_RPORTS-1:0][AW-1:0]       rd_addr_q;

   //////////////////////////////////////////////////////////////////////
   // Write ports
   //////////////////////////////////////////////////////////////////////

   // Ports are visited in ascending order, so the highest port wins
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         mem <= '0;
      end else begin
         for (int p = 0; p < NUM_WPORTS; p++) begin
            for (int l = 0; l < LANES; l++) begin
               if (wr_lane_en_i[p][l]) begin
                  mem[wr_addr_i[p]][l*LANE_W +: LANE_W] <=
                     wr_data_i[p][l*LANE_W +: LANE_W];
               end
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read ports, address stage then data stage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rd_en_q <= '0;
      end else begin
         rd_en_q <= rd_en_i;
      end
   end

   always_ff @(posedge clk_i) begin
      for (int p = 0; p < NUM_RPORTS; p++) begin
         if (rd_en_i[p]) begin
            rd_addr_q[p] <= rd_addr_i[p];
         end
      end
   end

   // Data register holds its value while the port is idle
   always_ff @(posedge clk_i) begin
      for (int p = 0; p < NUM_RPORTS; p++) begin
         if (rd_en_q[p]) begin
            rd_data_o[p] <= mem[rd_addr_q[p]];
         end
      end
   end

endmodule

//--- vlane_read_prep.sv
`timescale 1ns/1ps

module vlane_read_prep #(
   parameter int NUM_RPORTS = 4
) (
   input  logic                                    clk_i,
   input  logic                                    rst_i,

   input  logic [NUM_RPORTS-1:0][1:0]              el_idx_i,
   input  vlane_pkg::word_t [NUM_RPORTS-1:0]       rd_data_i,
   input  vlane_pkg::sew_e                         sew_i,
   output vlane_pkg::word_t [NUM_RPORTS-1:0]       elem_o
);

   // Element index waits for the RAM data
   localparam int IDX_STAGES = vlane_pkg::VRF_DELAY - 1;

   logic [IDX_STAGES-1:0][NUM_RPORTS-1:0][1:0]   el_idx_q;
   vlane_pkg::word_t [NUM_RPORTS-1:0]            elem_next;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         el_idx_q <= '0;
      end else begin
         el_idx_q[0] <= el_idx_i;
         for (int s = 1; s < IDX_STAGES; s++) begin
            el_idx_q[s] <= el_idx_q[s-1];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Element extraction
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < NUM_RPORTS; p++) begin
         case (sew_i)
            vlane_pkg::SEW8: begin
               elem_next[p] = {24'b0,
                  rd_data_i[p][el_idx_q[IDX_STAGES-1][p]*8 +: 8]};
            end
            vlane_pkg::SEW16: begin
               elem_next[p] = {16'b0,
                  rd_data_i[p][el_idx_q[IDX_STAGES-1][p][0]*16 +: 16]};
            end
            vlane_pkg::SEW32: begin
               elem_next[p] = rd_data_i[p];
            end
            default: begin
               elem_next[p] = '0;
            end
         endcase
      end
   end

   // Output stage lines up with the control pipeline's last stage
   always_ff @(posedge clk_i) begin
      elem_o <= elem_next;
   end

endmodule

//--- vlane_operand_route.sv
`timescale 1ns/1ps

module vlane_operand_route #(
   parameter int W_PORTS_NUM = 2
) (
   input  logic                                          clk_i,
   input  logic                                          rst_i,

   input  vlane_pkg::issue_t [W_PORTS_NUM-1:0]           issue_i,
   input  vlane_pkg::sew_e                               sew_i,
   input  vlane_pkg::word_t [2*W_PORTS_NUM-1:0]          elem_i,

   output vlane_pkg::sew_e                               sew_s2_o,
   output vlane_pkg::alu_req_t [W_PORTS_NUM-1:0]         alu_req_o,
   output vlane_pkg::word_t [W_PORTS_NUM-1:0]            store_data_o,
   output logic [W_PORTS_NUM-1:0]                        store_valid_o
);

   localparam int R_PORTS = 2 * W_PORTS_NUM;
   localparam int LAST    = vlane_pkg::VRF_DELAY - 1;

   vlane_pkg::issue_t [vlane_pkg::VRF_DELAY-1:0][W_PORTS_NUM-1:0]   issue_q;
   vlane_pkg::sew_e   [vlane_pkg::VRF_DELAY-1:0]                    sew_q;

   //////////////////////////////////////////////////////////////////////
   // Control pipeline beside the read data
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int s = 0; s < vlane_pkg::VRF_DELAY; s++) begin
            issue_q[s] <= '0;
            sew_q[s]   <= vlane_pkg::SEW_NONE;
         end
      end else begin
         issue_q[0] <= issue_i;
         sew_q[0]   <= sew_i;
         for (int s = 1; s < vlane_pkg::VRF_DELAY; s++) begin
            issue_q[s] <= issue_q[s-1];
            sew_q[s]   <= sew_q[s-1];
         end
      end
   end

   // Stage that meets the RAM data in read prep
   assign sew_s2_o = sew_q[LAST-1];

   //////////////////////////////////////////////////////////////////////
   // Operand and store muxes
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         alu_req_o[j].vld    = issue_q[LAST][j].read_valid;
         alu_req_o[j].opmode = issue_q[LAST][j].alu_ctrl;
         alu_req_o[j].sew    = sew_q[LAST];

         // op1 always from the even port of the pair
         alu_req_o[j].vs1 = elem_i[2*j];

         case (issue_q[LAST][j].op2_sel)
            vlane_pkg::OP2_VS2:  alu_req_o[j].vs2 = elem_i[2*j+1];
            vlane_pkg::OP2_XREG: alu_req_o[j].vs2 = issue_q[LAST][j].x_data;
            vlane_pkg::OP2_IMM:  alu_req_o[j].vs2 = {27'b0, issue_q[LAST][j].imm};
            default:             alu_req_o[j].vs2 = '0;
         endcase

         // Selects past the last read port give zero
         if (int'(issue_q[LAST][j].op3_sel) < R_PORTS) begin
            alu_req_o[j].vs3 = elem_i[issue_q[LAST][j].op3_sel];
         end else begin
            alu_req_o[j].vs3 = '0;
         end

         if (int'(issue_q[LAST][j].store_sel) < R_PORTS) begin
            store_data_o[j] = elem_i[issue_q[LAST][j].store_sel];
         end else begin
            store_data_o[j] = '0;
         end
         store_valid_o[j] = issue_q[LAST][j].store_valid;
      end
   end

endmodule

//--- vlane_writeback.sv
`timescale 1ns/1ps

module vlane_writeback #(
   parameter int W_PORTS_NUM = 2
) (
   input  logic                                          clk_i,
   input  logic                                          rst_i,

   input  vlane_pkg::wb_cmd_t [W_PORTS_NUM-1:0]          wb_cmd_i,
   input  logic [W_PORTS_NUM-1:0]                        alu_vld_i,
   input  vlane_pkg::word_t [W_PORTS_NUM-1:0]            alu_res_i,
   input  logic [W_PORTS_NUM-1:0]                        alu_mask_i,
   input  vlane_pkg::word_t                              load_data_i,
   input  logic [W_PORTS_NUM-1:0]                        mask_bit_i,

   output vlane_pkg::vrf_addr_t [W_PORTS_NUM-1:0]        vrf_waddr_o,
   output vlane_pkg::byte_en_t [W_PORTS_NUM-1:0]         vrf_wen_o,
   output vlane_pkg::word_t [W_PORTS_NUM-1:0]            vrf_wdata_o,
   output vlane_pkg::mask_addr_t [W_PORTS_NUM-1:0]       mask_waddr_o,
   output logic [W_PORTS_NUM-1:0]                        mask_wen_o,
   output logic [W_PORTS_NUM-1:0]                        mask_wdata_o
);

   localparam int LAST = vlane_pkg::WB_DELAY - 1;

   // One write-back stage per port
   typedef struct packed {
      vlane_pkg::wb_cmd_t  cmd;
      logic                en;
      vlane_pkg::word_t    wdata;
      logic                mask_wdata;
   } wb_stage_t;

   wb_stage_t [W_PORTS_NUM-1:0]                          stage_in;
   wb_stage_t [vlane_pkg::WB_DELAY-1:0][W_PORTS_NUM-1:0] pipe_q;

   //////////////////////////////////////////////////////////////////////
   // Data select in the command cycle
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         stage_in[j].cmd        = wb_cmd_i[j];
         stage_in[j].en         = alu_vld_i[j] | wb_cmd_i[j].force_wen;
         stage_in[j].mask_wdata = alu_mask_i[j];
         case (wb_cmd_i[j].data_sel)
            vlane_pkg::WD_ALU:  stage_in[j].wdata = alu_res_i[j];
            vlane_pkg::WD_LOAD: stage_in[j].wdata = load_data_i;
            default:            stage_in[j].wdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pipe_q <= '0;
      end else begin
         pipe_q[0] <= stage_in;
         for (int s = 1; s < vlane_pkg::WB_DELAY; s++) begin
            pipe_q[s] <= pipe_q[s-1];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Memory write ports
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int j = 0; j < W_PORTS_NUM; j++) begin
         vrf_waddr_o[j] = pipe_q[LAST][j].cmd.waddr;
         vrf_wdata_o[j] = pipe_q[LAST][j].wdata;
         vrf_wen_o[j]   = pipe_q[LAST][j].cmd.bwen & {4{pipe_q[LAST][j].en}};
         // Masked element keeps its old value
         if (pipe_q[LAST][j].cmd.vm && !mask_bit_i[j]) begin
            vrf_wen_o[j] = '0;
         end

         mask_waddr_o[j] = pipe_q[LAST][j].cmd.mask_addr;
         mask_wen_o[j]   = pipe_q[LAST][j].cmd.mask_wen & pipe_q[LAST][j].en;
         mask_wdata_o[j] = pipe_q[LAST][j].mask_wdata;
      end
   end

endmodule

//--- vector_lane.sv
`timescale 1ns/1ps

module vector_lane #(
   parameter int W_PORTS_NUM = 2
) (
   input  logic                                             clk_i,
   input  logic                                             rst_i,

   input  vlane_pkg::sew_e                                  vsew_i,
   input  vlane_pkg::vrf_rd_req_t [2*W_PORTS_NUM-1:0]       rd_req_i,
   input  vlane_pkg::issue_t [W_PORTS_NUM-1:0]              issue_i,
   input  vlane_pkg::wb_cmd_t [W_PORTS_NUM-1:0]             wb_cmd_i,
   input  vlane_pkg::word_t                                 load_data_i,

   // ALU interface
   input  logic [W_PORTS_NUM-1:0]                           alu_vld_i,
   input  vlane_pkg::word_t [W_PORTS_NUM-1:0]               alu_res_i,
   input  logic [W_PORTS_NUM-1:0]                           alu_mask_i,
   output vlane_pkg::alu_req_t [W_PORTS_NUM-1:0]            alu_req_o,

   // Store unit
   output vlane_pkg::word_t [W_PORTS_NUM-1:0]               store_data_o,
   output logic [W_PORTS_NUM-1:0]                           store_valid_o
);

   localparam int R_PORTS = 2 * W_PORTS_NUM;

   // Read side
   logic [R_PORTS-1:0]                            rd_en;
   vlane_pkg::vrf_addr_t [R_PORTS-1:0]            rd_addr;
   logic [R_PORTS-1:0][1:0]                       el_idx;
   vlane_pkg::word_t [R_PORTS-1:0]                vrf_rdata;
   vlane_pkg::word_t [R_PORTS-1:0]                elem;
   vlane_pkg::sew_e                               sew_s2;

   // Write side
   vlane_pkg::vrf_addr_t [W_PORTS_NUM-1:0]        vrf_waddr;
   vlane_pkg::byte_en_t [W_PORTS_NUM-1:0]         vrf_wen;
   vlane_pkg::word_t [W_PORTS_NUM-1:0]            vrf_wdata;

   // Mask file
   vlane_pkg::mask_addr_t [W_PORTS_NUM-1:0]       mask_raddr;
   logic [W_PORTS_NUM-1:0]                        mask_bit;
   vlane_pkg::mask_addr_t [W_PORTS_NUM-1:0]       mask_waddr;
   logic [W_PORTS_NUM-1:0]                        mask_wen;
   logic [W_PORTS_NUM-1:0]                        mask_wdata;

   for (genvar p = 0; p < R_PORTS; p++) begin : g_rd_req
      assign rd_en[p]   = rd_req_i[p].ren;
      assign rd_addr[p] = rd_req_i[p].addr;
      assign el_idx[p]  = rd_req_i[p].el_idx;
   end

   for (genvar j = 0; j < W_PORTS_NUM; j++) begin : g_mask_rd
      assign mask_raddr[j] = wb_cmd_i[j].mask_addr;
   end

   //////////////////////////////////////////////////////////////////////
   // Register files
   //////////////////////////////////////////////////////////////////////

   vlane_regfile #(
      .NUM_RPORTS (R_PORTS),
      .NUM_WPORTS (W_PORTS_NUM),
      .DEPTH      (vlane_pkg::VRF_DEPTH),
      .WIDTH      (32),
      .LANES      (4)
   ) u_vrf (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .rd_en_i      (rd_en),
      .rd_addr_i    (rd_addr),
      .rd_data_o    (vrf_rdata),
      .wr_addr_i    (vrf_waddr),
      .wr_lane_en_i (vrf_wen),
      .wr_data_i    (vrf_wdata)
   );

   // One mask read per write port, always enabled
   vlane_regfile #(
      .NUM_RPORTS (W_PORTS_NUM),
      .NUM_WPORTS (W_PORTS_NUM),
      .DEPTH      (vlane_pkg::MASK_DEPTH),
      .WIDTH      (1),
      .LANES      (1)
   ) u_vmrf (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .rd_en_i      ({W_PORTS_NUM{1'b1}}),
      .rd_addr_i    (mask_raddr),
      .rd_data_o    (mask_bit),
      .wr_addr_i    (mask_waddr),
      .wr_lane_en_i (mask_wen),
      .wr_data_i    (mask_wdata)
   );

   //////////////////////////////////////////////////////////////////////
   // Read path and write-back
   //////////////////////////////////////////////////////////////////////

   vlane_read_prep #(
      .NUM_RPORTS (R_PORTS)
   ) u_read_prep (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .el_idx_i  (el_idx),
      .rd_data_i (vrf_rdata),
      .sew_i     (sew_s2),
      .elem_o    (elem)
   );

   vlane_operand_route #(
      .W_PORTS_NUM (W_PORTS_NUM)
   ) u_operand_route (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .issue_i       (issue_i),
      .sew_i         (vsew_i),
      .elem_i        (elem),
      .sew_s2_o      (sew_s2),
      .alu_req_o     (alu_req_o),
      .store_data_o  (store_data_o),
      .store_valid_o (store_valid_o)
   );

   vlane_writeback #(
      .W_PORTS_NUM (W_PORTS_NUM)
   ) u_writeback (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .wb_cmd_i     (wb_cmd_i),
      .alu_vld_i    (alu_vld_i),
      .alu_res_i    (alu_res_i),
      .alu_mask_i   (alu_mask_i),
      .load_data_i  (load_data_i),
      .mask_bit_i   (mask_bit),
      .vrf_waddr_o  (vrf_waddr),
      .vrf_wen_o    (vrf_wen),
      .vrf_wdata_o  (vrf_wdata),
      .mask_waddr_o (mask_waddr),
      .mask_wen_o   (mask_wen),
      .mask_wdata_o (mask_wdata)
   );

endmodule

//--- vector_lane_checker.sv
`timescale 1ns/1ps

module vector_lane_checker #(
   parameter int W_PORTS_NUM = 2
) (
   input  logic                                       clk_i,
   input  logic                                       rst_i,
   input  vlane_pkg::issue_t [W_PORTS_NUM-1:0]        issue_i,
   input  vlane_pkg::wb_cmd_t [W_PORTS_NUM-1:0]       wb_cmd_i,
   input  vlane_pkg::alu_req_t [W_PORTS_NUM-1:0]      alu_req_o,
   input  logic [W_PORTS_NUM-1:0]                     store_valid_o
);

   int unsigned            fail_cnt = 0;
   logic [W_PORTS_NUM-1:0] vld;
   logic                   quiet;

   for (genvar j = 0; j < W_PORTS_NUM; j++) begin : g_vld
      assign vld[j] = alu_req_o[j].vld;
   end

   assign quiet = (vld == '0) && (store_valid_o == '0);

   //////////////////////////////////////////////////////////////////////
   // Outputs idle through reset and the pipeline refill
   //////////////////////////////////////////////////////////////////////

   a_quiet_in_reset: assert property (@(posedge clk_i) !rst_i |=> quiet)
      else begin
         fail_cnt++;
         $error("vld or store_valid high during reset");
      end

   a_quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_i) |-> quiet [*3])
      else begin
         fail_cnt++;
         $error("vld or store_valid high within three cycles of reset release");
      end

   for (genvar j = 0; j < W_PORTS_NUM; j++) begin : g_port
      a_op2_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
         issue_i[j].op2_sel inside {vlane_pkg::OP2_VS2, vlane_pkg::OP2_XREG,
                                    vlane_pkg::OP2_IMM})
         else begin
            fail_cnt++;
            $error("op2_sel outside its legal values on port %0d", j);
         end

      a_dsel_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
         wb_cmd_i[j].data_sel inside {vlane_pkg::WD_ALU, vlane_pkg::WD_LOAD,
                                      vlane_pkg::WD_ZERO})
         else begin
            fail_cnt++;
            $error("data_sel outside its legal values on port %0d", j);
         end

      // Request valid trails read_valid by the read latency
      a_vld_delay: assert property (@(posedge clk_i) disable iff (!rst_i)
         alu_req_o[j].vld == $past(issue_i[j].read_valid, vlane_pkg::VRF_DELAY))
         else begin
            fail_cnt++;
            $error("alu_req vld does not follow read_valid on port %0d", j);
         end
   end

endmodule

bind vector_lane vector_lane_checker #(
   .W_PORTS_NUM (W_PORTS_NUM)
) u_checker (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .issue_i       (issue_i),
   .wb_cmd_i      (wb_cmd_i),
   .alu_req_o     (alu_req_o),
   .store_valid_o (store_valid_o)
);

//--- tb_vector_lane.sv
`timescale 1ns/1ps

module tb_vector_lane;

   localparam int W_PORTS = 2;
   localparam int R_PORTS = 2 * W_PORTS;
   localparam int N_USED  = 8;
   // Stimulus runs a few hundred cycles
   localparam int MAX_CYCLES = 2000;

   // What the ALU and store unit should see for one issued read
   typedef struct packed {
      int                                   due;
      vlane_pkg::alu_req_t [W_PORTS-1:0]    req;
      vlane_pkg::word_t [W_PORTS-1:0]       st_data;
      logic [W_PORTS-1:0]                   st_vld;
   } exp_rd_t;

   logic                                    clk_i;
   logic                                    rst_i;
   vlane_pkg::sew_e                         vsew;
   vlane_pkg::vrf_rd_req_t [R_PORTS-1:0]    rd_req;
   vlane_pkg::issue_t [W_PORTS-1:0]         issue;
   vlane_pkg::wb_cmd_t [W_PORTS-1:0]        wb_cmd;
   vlane_pkg::word_t                        load_data;
   logic [W_PORTS-1:0]                      alu_vld;
   vlane_pkg::word_t [W_PORTS-1:0]          alu_res;
   logic [W_PORTS-1:0]                      alu_mask;
   vlane_pkg::alu_req_t [W_PORTS-1:0]       alu_req;
   vlane_pkg::word_t [W_PORTS-1:0]          store_data;
   logic [W_PORTS-1:0]                      store_valid;

   // Reference model of both memories
   vlane_pkg::word_t    ref_vrf [vlane_pkg::VRF_DEPTH];
   logic                ref_mask [vlane_pkg::MASK_DEPTH];
   vlane_pkg::vrf_addr_t used_addr [N_USED];

   // Reads in flight, oldest first
   exp_rd_t             exp_q [$];
   string               exp_name [$];

   // Read stimulus for the next read_check
   vlane_pkg::sew_e      sew_v;
   vlane_pkg::vrf_addr_t rd_addr_v [R_PORTS];
   logic [1:0]           rd_idx_v [R_PORTS];
   vlane_pkg::op2_sel_e  op2_v [W_PORTS];
   vlane_pkg::rport_sel_t op3_v [W_PORTS];
   vlane_pkg::rport_sel_t st_v [W_PORTS];
   logic                 stv_v [W_PORTS];
   vlane_pkg::word_t     x_v [W_PORTS];
   logic [4:0]           imm_v [W_PORTS];
   vlane_pkg::alu_ctrl_t ctl_v [W_PORTS];

   int seed = 67;
   int cycles = 0;
   int data_errors = 0;

   vector_lane #(
      .W_PORTS_NUM (W_PORTS)
   ) dut (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .vsew_i        (vsew),
      .rd_req_i      (rd_req),
      .issue_i       (issue),
      .wb_cmd_i      (wb_cmd),
      .load_data_i   (load_data),
      .alu_vld_i     (alu_vld),
      .alu_res_i     (alu_res),
      .alu_mask_i    (alu_mask),
      .alu_req_o     (alu_req),
      .store_data_o  (store_data),
      .store_valid_o (store_valid)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic step();
      @(posedge clk_i);
      #1;
   endtask

   // Element of a word by index and element width
   function automatic vlane_pkg::word_t elem_of(input vlane_pkg::word_t w,
                                                input logic [1:0] idx,
                                                input vlane_pkg::sew_e sew);
      case (sew)
         vlane_pkg::SEW8:  return (w >> (8 * idx)) & 32'h0000_00ff;
         vlane_pkg::SEW16: return (w >> (16 * idx[0])) & 32'h0000_ffff;
         vlane_pkg::SEW32: return w;
         default:          return '0;
      endcase
   endfunction

   task automatic check_val(input string what, input vlane_pkg::word_t exp,
                            input vlane_pkg::word_t act);
      assert (act === exp) else begin
         $display("** Error %s: expected %h, actual %h", what, exp, act);
         data_errors++;
      end
   endtask

   // One write command, then wait until it has reached the memory
   task automatic write_cmd(input int port, input vlane_pkg::vrf_addr_t addr,
                            input vlane_pkg::byte_en_t bwen,
                            input vlane_pkg::wdata_sel_e sel,
                            input vlane_pkg::word_t data, input logic vld,
                            input logic force_en, input logic vm,
                            input vlane_pkg::mask_addr_t maddr,
                            input logic mwen, input logic mbit);
      vlane_pkg::word_t wval;
      logic             en;
      wval = (sel == vlane_pkg::WD_ZERO) ? '0 : data;
      en   = vld | force_en;
      if (en && !(vm && !ref_mask[maddr])) begin
         for (int b = 0; b < 4; b++) begin
            if (bwen[b]) begin
               ref_vrf[addr][8*b +: 8] = wval[8*b +: 8];
            end
         end
      end
      if (en && mwen) begin
         ref_mask[maddr] = mbit;
      end

      wb_cmd[port] = '{waddr: addr, bwen: bwen, data_sel: sel, vm: vm,
                       mask_addr: maddr, mask_wen: mwen, force_wen: force_en};
      alu_vld[port]  = vld;
      alu_mask[port] = mbit;
      alu_res[port]  = (sel == vlane_pkg::WD_ALU) ? data : $random(seed);
      load_data      = (sel == vlane_pkg::WD_LOAD) ? data : $random(seed);
      step();
      wb_cmd   = '0;
      alu_vld  = '0;
      alu_mask = '0;
      step();
      step();
   endtask

   // Random reads of written addresses, SEW as given, op2 from the VRF
   task automatic pick_reads(input vlane_pkg::sew_e sew);
      sew_v = sew;
      for (int p = 0; p < R_PORTS; p++) begin
         rd_addr_v[p] = used_addr[$unsigned($random(seed)) % N_USED];
         rd_idx_v[p]  = 2'($random(seed));
      end
      for (int j = 0; j < W_PORTS; j++) begin
         op2_v[j] = vlane_pkg::OP2_VS2;
         op3_v[j] = 3'($unsigned($random(seed)) % R_PORTS);
         st_v[j]  = 3'($unsigned($random(seed)) % R_PORTS);
         stv_v[j] = 1'($random(seed));
         x_v[j]   = $random(seed);
         imm_v[j] = 5'($random(seed));
         ctl_v[j] = 6'($random(seed));
      end
   endtask

   // Issue one read on all ports and queue what should arrive three cycles later
   task automatic read_check(input string name);
      vlane_pkg::word_t e [R_PORTS];
      exp_rd_t          x;
      for (int p = 0; p < R_PORTS; p++) begin
         e[p] = elem_of(ref_vrf[rd_addr_v[p]], rd_idx_v[p], sew_v);
         rd_req[p] = '{ren: 1'b1, addr: rd_addr_v[p], el_idx: rd_idx_v[p]};
      end
      vsew  = sew_v;
      x.due = cycles + vlane_pkg::VRF_DELAY;
      for (int j = 0; j < W_PORTS; j++) begin
         issue[j] = '{op2_sel: op2_v[j], op3_sel: op3_v[j], x_data: x_v[j],
                      imm: imm_v[j], alu_ctrl: ctl_v[j], store_sel: st_v[j],
                      store_valid: stv_v[j], read_valid: 1'b1};
         x.req[j].vld    = 1'b1;
         x.req[j].opmode = ctl_v[j];
         x.req[j].sew    = sew_v;
         x.req[j].vs1    = e[2*j];
         case (op2_v[j])
            vlane_pkg::OP2_XREG: x.req[j].vs2 = x_v[j];
            vlane_pkg::OP2_IMM:  x.req[j].vs2 = {27'b0, imm_v[j]};
            default:             x.req[j].vs2 = e[2*j+1];
         endcase
         x.req[j].vs3  = e[op3_v[j]];
         x.st_data[j]  = e[st_v[j]];
         x.st_vld[j]   = stv_v[j];
      end
      exp_q.push_back(x);
      exp_name.push_back(name);
      step();
      rd_req = '0;
      issue  = '0;
      vsew   = vlane_pkg::SEW_NONE;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Output compare, one slot per cycle
   //////////////////////////////////////////////////////////////////////

   initial begin : compare_outputs
      exp_rd_t e;
      string   name;
      forever begin
         @(posedge clk_i);
         #3;
         if (exp_q.size() > 0 && exp_q[0].due == cycles) begin
            e    = exp_q.pop_front();
            name = exp_name.pop_front();
            for (int j = 0; j < W_PORTS; j++) begin
               check_val($sformatf("%s vld[%0d]", name, j), e.req[j].vld,
                         alu_req[j].vld);
               check_val($sformatf("%s opmode[%0d]", name, j), e.req[j].opmode,
                         alu_req[j].opmode);
               check_val($sformatf("%s sew[%0d]", name, j), e.req[j].sew,
                         alu_req[j].sew);
               check_val($sformatf("%s vs1[%0d]", name, j), e.req[j].vs1,
                         alu_req[j].vs1);
               check_val($sformatf("%s vs2[%0d]", name, j), e.req[j].vs2,
                         alu_req[j].vs2);
               check_val($sformatf("%s vs3[%0d]", name, j), e.req[j].vs3,
                         alu_req[j].vs3);
               check_val($sformatf("%s store_data[%0d]", name, j), e.st_data[j],
                         store_data[j]);
               check_val($sformatf("%s store_valid[%0d]", name, j), e.st_vld[j],
                         store_valid[j]);
            end
         end else begin
            for (int j = 0; j < W_PORTS; j++) begin
               check_val($sformatf("idle vld[%0d]", j), 0, alu_req[j].vld);
               check_val($sformatf("idle store_valid[%0d]", j), 0, store_valid[j]);
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      rst_i     = 1'b0;
      vsew      = vlane_pkg::SEW_NONE;
      rd_req    = '0;
      issue     = '0;
      wb_cmd    = '0;
      load_data = '0;
      alu_vld   = '0;
      alu_res   = '0;
      alu_mask  = '0;
      for (int a = 0; a < vlane_pkg::VRF_DEPTH; a++) begin
         ref_vrf[a] = '0;
      end
      for (int a = 0; a < vlane_pkg::MASK_DEPTH; a++) begin
         ref_mask[a] = 1'b0;
      end

      repeat (16) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      repeat (4) step();

      // Loads to random addresses on both write ports
      for (int i = 0; i < N_USED; i++) begin
         used_addr[i] = 6'($random(seed));
         write_cmd(i % 2, used_addr[i], 4'hf, vlane_pkg::WD_LOAD, $random(seed),
                   1'b0, 1'b1, 1'b0, '0, 1'b0, 1'b0);
      end
      for (int i = 0; i < N_USED; i++) begin
         pick_reads(vlane_pkg::SEW32);
         rd_addr_v[0] = used_addr[i];
         rd_addr_v[1] = used_addr[i];
         read_check("load");
      end

      // Element extraction for every index
      for (int s = 0; s < 4; s++) begin
         for (int idx = 0; idx < 4; idx++) begin
            pick_reads(vlane_pkg::sew_e'(s));
            for (int p = 0; p < R_PORTS; p++) begin
               rd_idx_v[p] = 2'(idx);
            end
            read_check("elem");
         end
      end

      // Operand selection across all read ports
      for (int o = 0; o < 3; o++) begin
         for (int q = 0; q < R_PORTS; q++) begin
            pick_reads(vlane_pkg::SEW32);
            op2_v[0] = vlane_pkg::op2_sel_e'(o);
            op2_v[1] = vlane_pkg::op2_sel_e'(o);
            op3_v[0] = 3'(q);
            op3_v[1] = 3'(R_PORTS - 1 - q);
            read_check("route");
         end
      end

      // ALU results with partial byte enables
      for (int i = 0; i < 4; i++) begin
         write_cmd(i % 2, used_addr[i], 4'(1 << i) | 4'(i), vlane_pkg::WD_ALU,
                   $random(seed), 1'b1, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         pick_reads(vlane_pkg::SEW32);
         rd_addr_v[0] = used_addr[i];
         rd_addr_v[2] = used_addr[i];
         read_check("alu_bwen");
      end

      // Neither alu_vld_i nor force_wen
      write_cmd(0, used_addr[5], 4'hf, vlane_pkg::WD_ZERO, '0,
                1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
      write_cmd(1, used_addr[6], 4'hf, vlane_pkg::WD_LOAD, $random(seed),
                1'b0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
      pick_reads(vlane_pkg::SEW32);
      rd_addr_v[0] = used_addr[5];
      rd_addr_v[1] = used_addr[6];
      read_check("no_enable");

      // Mask bits from the ALU, then masked writes through them
      for (int m = 0; m < 2; m++) begin
         write_cmd(m, '0, 4'h0, vlane_pkg::WD_ALU, '0, 1'b1, 1'b0, 1'b0,
                   5'(7 + m), 1'b1, 1'b1);
      end
      write_cmd(0, '0, 4'h0, vlane_pkg::WD_ALU, '0, 1'b1, 1'b0, 1'b0,
                5'd7, 1'b1, 1'b0);
      for (int m = 0; m < 2; m++) begin
         write_cmd(m, used_addr[2 + m], 4'hf, vlane_pkg::WD_ALU, $random(seed),
                   1'b1, 1'b0, 1'b1, 5'(7 + m), 1'b0, 1'b0);
      end
      pick_reads(vlane_pkg::SEW32);
      rd_addr_v[0] = used_addr[2];
      rd_addr_v[1] = used_addr[3];
      read_check("mask");

      repeat (4) step();
      $display("Done after %0d cycles: %0d data errors, %0d assertion failures",
               cycles, data_errors, dut.u_checker.fail_cnt);
      if (data_errors == 0 && dut.u_checker.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
vlane_pkg.sv
vlane_regfile.sv
vlane_read_prep.sv
vlane_operand_route.sv
vlane_writeback.sv
vector_lane.sv
vector_lane_checker.sv
tb_vector_lane.sv
